//--- bench/pe_trace.txt
# T test, E expected dout_pe hex (re im), I program word hex, W idle cycles
# D din_v din_ld din_pe, R din_v din_ld with random din_pe
T 1
W 20
T 2
E 90001000
E 5000F000
I 4000
I 4400
I 0010
I 1010
D 1 70008000 00000000
R 1 20009000
R 0 00000000
R 0 00000000
T 3
E 3000F000
E 0FFF3000
I 4000
I 4400
I 2010
I 3010
R 1 40002001
R 1 4000C000
R 0 00000000
R 0 00000000
T 4
E 20002000
E 10001000
I 8000
I 4400
I 2010
I 4C00
I 4C00
I C800
I 2210
D 1 00000000 40004000
R 1 40000000
R 0 00000000
R 0 00000000
R 0 00000000
R 1 00000000
R 0 00000000
T 5
E 11002200
E 11002200
E 00030003
I 4000
I 4400
I 0010
R 1 10002000
R 1 01000200
R 0 00000000
R 0 7FFF7FFF
R 0 7FFF7FFF
R 0 00000000
R 1 00010001
R 1 00020002
R 0 00000000
T 6
E 6000C000
E 00003000
E 6000C000
E 00003000
E 6000C000
E 00003000
I 4000
I 4400
I 1010
I 2010
R 1 60000000
R 1 00004000
R 0 00000000
R 0 00000000

//--- sim.f
logic/pe_pkg.sv
logic/inst_mem.sv
logic/control.sv
logic/data_mem.sv
logic/complex_alu.sv
logic/pe.sv
bench/pe_checker.sv
bench/pe_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the PE testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module pe_tb -f sim.f -o pe_sim \
    > build.log 2>&1 \
    && ./obj_dir/pe_sim > sim.log 2>&1 \
    || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

//--- bench/pe_tb.sv
`timescale 1ns/10ps

module pe_tb;

    // DUT inputs
    logic               clk;
    logic               reset;
    logic               inst_v;
    pe_pkg::inst_word_u inst_in;
    logic               din_v;
    pe_pkg::cplx_t      din_ld;
    pe_pkg::cplx_t      din_pe;

    // DUT outputs
    pe_pkg::cplx_t      dout_pe;
    logic               dout_v;

    // Checker control and trace parsing
    logic               idle_chk;
    integer             seed;
    integer             fd;
    integer             rc;
    integer             num;
    logic [7:0]         tag;
    logic [31:0]        word;
    logic [31:0]        ld_val;
    logic [31:0]        pe_val;
    logic [8*128-1:0]   line_buf;
    int                 test_id;
    bit                 in_test;
    bit                 need_gap;

    pe UUT (
        .clk     (clk),
        .reset   (reset),
        .inst_v  (inst_v),
        .inst_in (inst_in),
        .din_v   (din_v),
        .din_ld  (din_ld),
        .din_pe  (din_pe),
        .dout_pe (dout_pe),
        .dout_v  (dout_v)
    );

    pe_checker chk (
        .clk      (clk),
        .reset    (reset),
        .dout_pe  (dout_pe),
        .dout_v   (dout_v),
        .idle_chk (idle_chk)
    );

    // 40 ns period
    always #20 clk = ~clk;

    //////////////////////////////////////////////////////////////
    // Cycle helpers
    //////////////////////////////////////////////////////////////

    // Next drive point 2 ns past the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic apply_reset();
        reset  = 1'b1;
        inst_v = 1'b0;
        din_v  = 1'b0;
        repeat (3) next_cycle();
        reset  = 1'b0;
    endtask

    // Let the looping program run until every listed result arrived
    task automatic finish_test();
        int wait_cnt;
        wait_cnt = 0;
        inst_v   = 1'b0;
        din_v    = 1'b0;
        while (chk.pending() > 0 && wait_cnt < 64) begin
            din_pe = $random(seed);
            next_cycle();
            wait_cnt++;
        end
        if (chk.pending() > 0) begin
            $display("Timeout in test %0d: %0d results never came on dout_v",
                     test_id, chk.pending());
            chk.add_error();
        end
        chk.end_test();
    endtask

    //////////////////////////////////////////////////////////////
    // Trace replay
    //////////////////////////////////////////////////////////////

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        inst_v   = 1'b0;
        inst_in  = '0;
        din_v    = 1'b0;
        din_ld   = '0;
        din_pe   = '0;
        idle_chk = 1'b0;
        seed     = 87;
        in_test  = 1'b0;
        need_gap = 1'b0;
        test_id  = 0;
        fd = $fopen("bench/pe_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file bench/pe_trace.txt");
            $display("Some tests failed");
            $finish;
        end else begin
            while ($fscanf(fd, " %c", tag) == 1) begin
                case (tag)
                    "#": rc = $fgets(line_buf, fd);
                    "T": begin
                        if (in_test) finish_test();
                        rc = $fscanf(fd, "%d", num);
                        test_id = num;
                        in_test = 1'b1;
                        chk.start_test(test_id);
                        apply_reset();
                    end
                    "E": begin
                        rc = $fscanf(fd, "%h", word);
                        chk.push_expected(word);
                    end
                    "I": begin
                        rc = $fscanf(fd, "%h", word);
                        inst_v   = 1'b1;
                        inst_in  = word[15:0];
                        need_gap = 1'b1;
                        next_cycle();
                    end
                    "D", "R": begin
                        if (tag == "D") begin
                            rc = $fscanf(fd, "%d %h %h", num, ld_val, pe_val);
                        end else begin
                            rc = $fscanf(fd, "%d %h", num, ld_val);
                            pe_val = $random(seed);
                        end
                        // One quiet cycle so record k meets instruction k
                        if (need_gap) begin
                            inst_v   = 1'b0;
                            din_v    = 1'b0;
                            need_gap = 1'b0;
                            next_cycle();
                        end
                        din_v  = num[0];
                        din_ld = ld_val;
                        din_pe = pe_val;
                        next_cycle();
                    end
                    "W": begin
                        rc = $fscanf(fd, "%d", num);
                        idle_chk = 1'b1;
                        repeat (num) begin
                            din_pe = $random(seed);
                            next_cycle();
                        end
                        idle_chk = 1'b0;
                    end
                    default: begin
                        $display("Unknown record in trace file, tag %0d", tag);
                        chk.add_error();
                    end
                endcase
            end
            $fclose(fd);
            if (in_test) finish_test();
            chk.summary();
            if (chk.error_total() == 0) begin
                $display("All tests passed");
            end else begin
                $display("Some tests failed");
            end
            $finish;
        end
    end

endmodule

//--- bench/pe_checker.sv
`timescale 1ns/10ps

module pe_checker (
    input  logic          clk,
    input  logic          reset,
    input  pe_pkg::cplx_t dout_pe,
    input  logic          dout_v,
    input  logic          idle_chk
);

    // Results still owed by the DUT in order
    logic [pe_pkg::data_width-1:0] exp_q [$];
    logic [pe_pkg::data_width-1:0] exp_val;

    // Per-test and overall tallies
    int cur_test;
    int test_checks;
    int test_errors;
    int total_errors;
    int tests_run;
    int tests_failed;

    initial begin
        cur_test     = 0;
        test_checks  = 0;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
    end

    //////////////////////////////////////////////////////////////
    // Sampled at the rising edge before the DUT updates
    //////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!reset) begin
            // Outputs stay quiet with no program loaded
            if (idle_chk) begin
                test_checks++;
                if (dout_v !== 1'b0) begin
                    $display("Fail test %0d: dout_v got %0h expected 0", cur_test, dout_v);
                    test_errors++;
                end
                if (dout_pe !== '0) begin
                    $display("Fail test %0d: dout_pe got %08h expected 00000000",
                             cur_test, dout_pe);
                    test_errors++;
                end
            end
            // Pulses past the listed results are later passes of the loop
            if (dout_v === 1'b1 && exp_q.size() > 0) begin
                exp_val = exp_q.pop_front();
                test_checks++;
                if (dout_pe !== exp_val) begin
                    $display("Fail test %0d: dout_pe got %08h expected %08h",
                             cur_test, dout_pe, exp_val);
                    test_errors++;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////
    // Calls from the testbench top
    //////////////////////////////////////////////////////////////

    task automatic start_test(input int id);
        cur_test = id;
        exp_q.delete();
    endtask

    task automatic push_expected(input logic [pe_pkg::data_width-1:0] val);
        exp_q.push_back(val);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic add_error();
        test_errors++;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
            $display("Test %0d failed, %0d errors in %0d checks",
                     cur_test, test_errors, test_checks);
        end else begin
            $display("Test %0d passed, %0d checks", cur_test, test_checks);
        end
        total_errors += test_errors;
        test_errors  = 0;
        test_checks  = 0;
    endtask

    task automatic summary();
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, total_errors);
    endtask

    function automatic int error_total();
        return total_errors + test_errors;
    endfunction

endmodule

//--- logic/pe.sv
`timescale 1ns/10ps

module pe (
    input  logic               clk,
    input  logic               reset,
    input  logic               inst_v,
    input  pe_pkg::inst_word_u inst_in,
    input  logic               din_v,
    input  pe_pkg::cplx_t      din_ld,
    input  pe_pkg::cplx_t      din_pe,
    output pe_pkg::cplx_t      dout_pe,
    output logic               dout_v
);

    // Instruction path
    pe_pkg::inst_word_u inst_out;
    logic               inst_ok;
    pe_pkg::dmem_ctrl_t dmem_ctrl;
    pe_pkg::alu_ctrl_t  alu_ctrl;

    // Operand path
    pe_pkg::cplx_t      rdata_a;
    pe_pkg::cplx_t      rdata_b;
    pe_pkg::cplx_t      din_wb;

    // Current output fed back for writeback moves
    assign din_wb = dout_pe;

    ////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////

    inst_mem imem (
        .clk      (clk),
        .reset    (reset),
        .inst_v   (inst_v),
        .inst_in  (inst_in),
        .inst_out (inst_out),
        .inst_ok  (inst_ok)
    );

    control ctrl (
        .inst      (inst_out),
        .inst_ok   (inst_ok),
        .din_v     (din_v),
        .dmem_ctrl (dmem_ctrl),
        .alu_ctrl  (alu_ctrl)
    );

    data_mem dmem (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (dmem_ctrl),
        .din_ld  (din_ld),
        .din_pe  (din_pe),
        .din_wb  (din_wb),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    complex_alu alu (
        .clk    (clk),
        .reset  (reset),
        .ctrl   (alu_ctrl),
        .din_a  (rdata_a),
        .din_b  (rdata_b),
        .dout   (dout_pe),
        .dout_v (dout_v)
    );

endmodule

//--- logic/complex_alu.sv
`timescale 1ns/10ps

module complex_alu (
    input  logic              clk,
    input  logic              reset,
    input  pe_pkg::alu_ctrl_t ctrl,
    input  pe_pkg::cplx_t     din_a,
    input  pe_pkg::cplx_t     din_b,
    output pe_pkg::cplx_t     dout,
    output logic              dout_v
);

    // Control aligned with the read data
    pe_pkg::alu_ctrl_t ctrl_d;

    // Stage one
    logic                                   s1_v;
    pe_pkg::alu_op_e                        s1_op;
    logic signed [pe_pkg::data_width-1:0]   p_rr;
    logic signed [pe_pkg::data_width-1:0]   p_ii;
    logic signed [pe_pkg::data_width-1:0]   p_ri;
    logic signed [pe_pkg::data_width-1:0]   p_ir;
    pe_pkg::cplx_t                          s1_sum;

    // Stage two accumulators wrapping at 32 bits
    logic signed [pe_pkg::data_width-1:0]   acc_re;
    logic signed [pe_pkg::data_width-1:0]   acc_im;

    ////////////////////////////////////////////////////////////
    // Valid pipe
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_d <= '0;
            s1_v   <= 1'b0;
        end else begin
            ctrl_d <= ctrl;
            s1_v   <= ctrl_d.issue;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage one products or sums
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        s1_op <= ctrl_d.op;
        // Four partial products
        p_rr  <= din_a.re * din_b.re;
        p_ii  <= din_a.im * din_b.im;
        p_ri  <= din_a.re * din_b.im;
        p_ir  <= din_a.im * din_b.re;
        // Sum or difference with 16-bit wrap
        if (ctrl_d.op == pe_pkg::op_sub) begin
            s1_sum.re <= din_a.re - din_b.re;
            s1_sum.im <= din_a.im - din_b.im;
        end else begin
            s1_sum.re <= din_a.re + din_b.re;
            s1_sum.im <= din_a.im + din_b.im;
        end
    end

    // Conjugate flips the sign of the b imaginary terms
    always_comb begin
        if (s1_op == pe_pkg::op_cmul) begin
            acc_re = p_rr + p_ii;
            acc_im = p_ir - p_ri;
        end else begin
            acc_re = p_rr - p_ii;
            acc_im = p_ri + p_ir;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage two result register
    ////////////////////////////////////////////////////////////

    // Holds between pulses
    always_ff @(posedge clk) begin
        if (reset) begin
            dout   <= '0;
            dout_v <= 1'b0;
        end else begin
            dout_v <= s1_v;
            if (s1_v) begin
                if (s1_op == pe_pkg::op_add || s1_op == pe_pkg::op_sub) begin
                    dout <= s1_sum;
                end else begin
                    // Shift by 15 and truncate to Q1.15
                    dout.re <= acc_re[pe_pkg::frac_bits +: pe_pkg::half_width];
                    dout.im <= acc_im[pe_pkg::frac_bits +: pe_pkg::half_width];
                end
            end
        end
    end

    // Read data defined when the aligned issue reaches stage one
    assert property (@(posedge clk) disable iff (reset)
        ctrl_d.issue |-> !$isunknown({din_a, din_b}))
        else $error("complex_alu: operands unknown at issue");

endmodule

//--- logic/data_mem.sv
`timescale 1ns/10ps

module data_mem (
    input  logic               clk,
    input  logic               reset,
    input  pe_pkg::dmem_ctrl_t ctrl,
    input  pe_pkg::cplx_t      din_ld,
    input  pe_pkg::cplx_t      din_pe,
    input  pe_pkg::cplx_t      din_wb,
    output pe_pkg::cplx_t      rdata_a,
    output pe_pkg::cplx_t      rdata_b
);

    // Complex register file
    pe_pkg::cplx_t mem [pe_pkg::dmem_depth];

    // Selected write word
    pe_pkg::cplx_t wdata;

    ////////////////////////////////////////////////////////////
    // Write path
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (ctrl.wsel)
            pe_pkg::wr_src_ld: wdata = din_ld;
            pe_pkg::wr_src_pe: wdata = din_pe;
            default:           wdata = din_wb;
        endcase
    end

    // Whole file cleared on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < pe_pkg::dmem_depth; i++) begin
                mem[i] <= '0;
            end
        end else if (ctrl.wren) begin
            mem[ctrl.waddr] <= wdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////////////

    // Registered, old contents only
    // Data valid the cycle after rden
    always_ff @(posedge clk) begin
        if (ctrl.rden) begin
            rdata_a <= mem[ctrl.raddr_a];
            rdata_b <= mem[ctrl.raddr_b];
        end
    end

    // Decoder issues either a move or a compute per cycle
    assert property (@(posedge clk) disable iff (reset)
        !(ctrl.wren && ctrl.rden))
        else $error("data_mem: write and read in the same cycle");

endmodule

//--- logic/control.sv
`timescale 1ns/10ps

module control (
    input  pe_pkg::inst_word_u inst,
    input  logic               inst_ok,
    input  logic               din_v,
    output pe_pkg::dmem_ctrl_t dmem_ctrl,
    output pe_pkg::alu_ctrl_t  alu_ctrl
);

    // Kind sits at the top of both views
    pe_pkg::inst_kind_e kind;

    assign kind = inst.compute.kind;

    ////////////////////////////////////////////////////////////
    // Decoder
    ////////////////////////////////////////////////////////////

    always_comb begin
        // Idle defaults
        dmem_ctrl      = '0;
        dmem_ctrl.wsel = pe_pkg::wr_src_ld;
        alu_ctrl       = '0;
        alu_ctrl.op    = pe_pkg::op_add;

        if (inst_ok) begin
            case (kind)
                pe_pkg::kind_compute: begin
                    // Both operands read, result issued to the ALU
                    dmem_ctrl.rden    = 1'b1;
                    dmem_ctrl.raddr_a = inst.compute.src_a;
                    dmem_ctrl.raddr_b = inst.compute.src_b;
                    alu_ctrl.issue    = 1'b1;
                    alu_ctrl.op       = inst.compute.alu_op;
                end
                pe_pkg::kind_load_ld: begin
                    // Local load port
                    dmem_ctrl.wren  = din_v;
                    dmem_ctrl.waddr = inst.move.dst;
                    dmem_ctrl.wsel  = pe_pkg::wr_src_ld;
                end
                pe_pkg::kind_load_pe: begin
                    // Neighbor value
                    dmem_ctrl.wren  = din_v;
                    dmem_ctrl.waddr = inst.move.dst;
                    dmem_ctrl.wsel  = pe_pkg::wr_src_pe;
                end
                default: begin
                    // Writeback of the current output
                    dmem_ctrl.wren  = din_v;
                    dmem_ctrl.waddr = inst.move.dst;
                    dmem_ctrl.wsel  = pe_pkg::wr_src_wb;
                end
            endcase
        end
    end

endmodule

//--- logic/inst_mem.sv
`timescale 1ns/10ps

module inst_mem (
    input  logic               clk,
    input  logic               reset,
    input  logic               inst_v,
    input  pe_pkg::inst_word_u inst_in,
    output pe_pkg::inst_word_u inst_out,
    output logic               inst_ok
);

    // Program store
    pe_pkg::inst_word_u store [pe_pkg::imem_depth];

    // Load side
    logic [pe_pkg::pc_width-1:0] load_ptr;
    // One extra bit so a full store is visible
    logic [pe_pkg::pc_width:0]   inst_cnt;

    // Replay side
    logic [pe_pkg::pc_width-1:0] pc;
    logic                        last_slot;

    assign last_slot = ({1'b0, pc} == inst_cnt - 1'b1);

    ////////////////////////////////////////////////////////////
    // Pointers and replay counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            load_ptr <= '0;
            inst_cnt <= '0;
            pc       <= '0;
            inst_ok  <= 1'b0;
        end else if (inst_v) begin
            // Loading, counter parked at slot 0
            load_ptr <= load_ptr + 1'b1;
            inst_cnt <= inst_cnt + 1'b1;
            pc       <= '0;
            inst_ok  <= 1'b0;
        end else if (inst_cnt != '0) begin
            // Replay, wrap after the last loaded slot
            inst_ok  <= 1'b1;
            pc       <= last_slot ? '0 : pc + 1'b1;
        end else begin
            inst_ok  <= 1'b0;
        end
    end

    // Store write and registered fetch
    always_ff @(posedge clk) begin
        if (inst_v) begin
            store[load_ptr] <= inst_in;
        end
        inst_out <= store[pc];
    end

    // Loader must stop once all slots hold a program word
    assert property (@(posedge clk) disable iff (reset)
        inst_v |-> (inst_cnt < pe_pkg::imem_depth))
        else $error("inst_mem: load strobe with full store");

endmodule

//--- logic/pe_pkg.sv
package pe_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and depths
    ////////////////////////////////////////////////////////////

    // One real or imaginary part, Q1.15
    localparam int half_width = 16;
    // One complex word
    localparam int data_width = 32;

    // Data memory geometry
    localparam int addr_width = 4;
    localparam int dmem_depth = 16;

    // Instruction memory geometry
    localparam int imem_depth = 16;
    localparam int pc_width   = 4;
    localparam int inst_width = 16;

    // Product realignment shift
    localparam int frac_bits  = 15;

    ////////////////////////////////////////////////////////////
    // Data and instruction types
    ////////////////////////////////////////////////////////////

    // Real part in the upper half
    typedef struct packed {
        logic signed [half_width-1:0] re;
        logic signed [half_width-1:0] im;
    } cplx_t;

    // Top two bits of every instruction
    typedef enum logic [1:0] {
        kind_compute   = 2'd0,
        kind_load_ld   = 2'd1,
        kind_load_pe   = 2'd2,
        kind_writeback = 2'd3
    } inst_kind_e;

    // op_cmul multiplies by the conjugate of operand b
    typedef enum logic [1:0] {
        op_add  = 2'd0,
        op_sub  = 2'd1,
        op_mul  = 2'd2,
        op_cmul = 2'd3
    } alu_op_e;

    // Compute view
    typedef struct packed {
        inst_kind_e                kind;
        alu_op_e                   alu_op;
        logic [addr_width-1:0]     src_a;
        logic [addr_width-1:0]     src_b;
        logic [inst_width-13:0]    spare;
    } inst_compute_t;

    // Move view, shared by the three write kinds
    typedef struct packed {
        inst_kind_e                kind;
        logic [addr_width-1:0]     dst;
        logic [inst_width-7:0]     spare;
    } inst_move_t;

    // Same word, picked by kind
    typedef union packed {
        inst_compute_t compute;
        inst_move_t    move;
    } inst_word_u;

    ////////////////////////////////////////////////////////////
    // Control bundles
    ////////////////////////////////////////////////////////////

    // Write data select
    typedef enum logic [1:0] {
        wr_src_ld = 2'd0,
        wr_src_pe = 2'd1,
        wr_src_wb = 2'd2
    } wr_src_e;

    typedef struct packed {
        logic                  wren;
        logic [addr_width-1:0] waddr;
        logic                  rden;
        logic [addr_width-1:0] raddr_a;
        logic [addr_width-1:0] raddr_b;
        wr_src_e               wsel;
    } dmem_ctrl_t;

    typedef struct packed {
        logic    issue;
        alu_op_e op;
    } alu_ctrl_t;

endpackage
